//--- weight_mem_consts.svh
`ifndef WEIGHT_MEM_CONSTS_SVH
`define WEIGHT_MEM_CONSTS_SVH

// bank organisation
`define WM_BANKS 4
`define WM_BANKS_LOG 2

// weights per bank word and bits per weight
`define WM_LANES 4
`define WM_WEIGHT_W 8

// row address inside one bank
`define WM_ROW_W 8
`define WM_ROWS (1 << `WM_ROW_W)

// external cnn / fc address
`define WM_ADDR_W 12

`endif

//--- weight_mem_pkg.sv
`default_nettype none
`include "weight_mem_consts.svh"

package weight_mem_pkg;

	typedef logic signed [`WM_WEIGHT_W-1:0] weight_t;

	typedef logic [`WM_LANES*$bits(weight_t)-1:0] bank_word_t; // one bank row
	typedef logic [`WM_BANKS*$bits(bank_word_t)-1:0] fc_word_t; // bank 0 in the lsbs

	typedef logic [`WM_ROW_W-1:0] row_addr_t;
	typedef logic [`WM_ADDR_W-1:0] ext_addr_t;
	typedef logic [`WM_BANKS_LOG-1:0] bank_idx_t;

	// 3-bit mode field of the accelerator
	typedef enum logic [2:0] {
		MODE_CNN = 3'd1,
		MODE_FC = 3'd2
	} wm_mode_e;

	// kind of read in flight
	typedef enum logic [1:0] {
		RD_NONE,
		RD_CNN,
		RD_FC
	} rd_kind_e;

endpackage

`default_nettype wire

//--- bank_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface bank_port_if;
	import weight_mem_pkg::*;

	logic wr_en;
	row_addr_t wr_row;
	bank_word_t wr_data;

	logic rd_en;
	row_addr_t rd_row;
	bank_word_t rd_data; // valid the cycle after rd_en

	modport decoder (
		output wr_en,
		output wr_row,
		output wr_data,
		output rd_en,
		output rd_row
	);

	modport bank (
		input wr_en,
		input wr_row,
		input wr_data,
		input rd_en,
		input rd_row,
		output rd_data
	);

endinterface

`default_nettype wire

//--- weight_addr_decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "weight_mem_consts.svh"

module weight_addr_decode (
	input logic clk,
	input logic reset,
	input logic wr_en_cnn,
	input logic wr_en_fc,
	input logic rd_en,
	input weight_mem_pkg::wm_mode_e mode,
	input weight_mem_pkg::ext_addr_t wr_addr_cnn,
	input weight_mem_pkg::ext_addr_t wr_addr_fc,
	input weight_mem_pkg::ext_addr_t rd_addr_cnn,
	input weight_mem_pkg::ext_addr_t rd_addr_fc,
	input weight_mem_pkg::bank_word_t wr_data_cnn,
	input weight_mem_pkg::bank_word_t wr_data_fc,
	input weight_mem_pkg::row_addr_t fc_base,
	bank_port_if.decoder banks [`WM_BANKS],
	output weight_mem_pkg::rd_kind_e rd_kind,
	output logic [1:0] rd_bank
);
	import weight_mem_pkg::*;

	bank_idx_t cnn_wr_bank;
	bank_idx_t fc_wr_bank;
	bank_idx_t cnn_rd_bank;
	row_addr_t cnn_wr_row;
	row_addr_t fc_wr_row;
	row_addr_t cnn_rd_row;
	row_addr_t fc_rd_row;
	logic rd_is_cnn;
	logic rd_is_fc;
	logic [`WM_BANKS-1:0] cnn_wr_sel;
	logic [`WM_BANKS-1:0] fc_wr_sel;
	logic [`WM_BANKS-1:0] bank_wr_en;
	logic [`WM_BANKS-1:0] bank_rd_en;
	row_addr_t bank_wr_row [`WM_BANKS];
	bank_word_t bank_wr_data [`WM_BANKS];
	row_addr_t bank_rd_row [`WM_BANKS];

	// cnn bank field sits right above the row bits
	function automatic bank_idx_t cnn_bank(ext_addr_t addr);
		return addr[`WM_ROW_W +: `WM_BANKS_LOG];
	endfunction

	function automatic bank_idx_t fc_bank(ext_addr_t addr);
		return addr[`WM_BANKS_LOG +: `WM_BANKS_LOG];
	endfunction

	// bank bits squeezed out of the fc address and the base pointer added
	function automatic row_addr_t fc_row(ext_addr_t addr, row_addr_t base);
		row_addr_t offset;
		offset = row_addr_t'({addr[`WM_ADDR_W-1:2*`WM_BANKS_LOG], addr[`WM_BANKS_LOG-1:0]});
		return base + offset; // wraps mod rows
	endfunction

	assign cnn_wr_bank = cnn_bank(wr_addr_cnn);
	assign cnn_wr_row = wr_addr_cnn[`WM_ROW_W-1:0];
	assign fc_wr_bank = fc_bank(wr_addr_fc);
	assign fc_wr_row = fc_row(wr_addr_fc, fc_base);

	assign cnn_rd_bank = cnn_bank(rd_addr_cnn);
	assign cnn_rd_row = rd_addr_cnn[`WM_ROW_W-1:0];
	assign fc_rd_row = fc_row(rd_addr_fc, fc_base);

	assign rd_is_cnn = rd_en && (mode == MODE_CNN);
	assign rd_is_fc = rd_en && (mode == MODE_FC);

	always_comb begin
		for (int b = 0; b < `WM_BANKS; b++) begin
			cnn_wr_sel[b] = wr_en_cnn && (cnn_wr_bank == bank_idx_t'(b));
			fc_wr_sel[b] = wr_en_fc && (fc_wr_bank == bank_idx_t'(b));
			bank_wr_en[b] = cnn_wr_sel[b] || fc_wr_sel[b];
			// fc write wins a shared bank
			bank_wr_row[b] = fc_wr_sel[b] ? fc_wr_row : cnn_wr_row;
			bank_wr_data[b] = fc_wr_sel[b] ? wr_data_fc : wr_data_cnn;

			bank_rd_en[b] = rd_is_fc || (rd_is_cnn && (cnn_rd_bank == bank_idx_t'(b)));
			bank_rd_row[b] = rd_is_fc ? fc_rd_row : cnn_rd_row; // fc reads one row everywhere
		end
	end

	for (genvar g = 0; g < `WM_BANKS; g++) begin : g_req
		assign banks[g].wr_en = bank_wr_en[g];
		assign banks[g].wr_row = bank_wr_row[g];
		assign banks[g].wr_data = bank_wr_data[g];
		assign banks[g].rd_en = bank_rd_en[g];
		assign banks[g].rd_row = bank_rd_row[g];
	end

	// tag travels alongside the bank read latency
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rd_kind <= RD_NONE;
			rd_bank <= '0;
		end else begin
			if (rd_is_cnn)
				rd_kind <= RD_CNN;
			else if (rd_is_fc)
				rd_kind <= RD_FC;
			else
				rd_kind <= RD_NONE;
			rd_bank <= cnn_rd_bank;
		end
	end

	a_wr_en_known: assert property (@(posedge clk) disable iff (!reset)
		!$isunknown({wr_en_cnn, wr_en_fc}))
		else $error("write enable unknown");

	a_rd_en_known: assert property (@(posedge clk) disable iff (!reset)
		!$isunknown(rd_en))
		else $error("rd_en unknown");

endmodule

`default_nettype wire

//--- weight_bank.sv
`timescale 1ns/1ns
`default_nettype none
`include "weight_mem_consts.svh"

module weight_bank (
	input logic clk,
	bank_port_if.bank port
);
	import weight_mem_pkg::*;

	bank_word_t mem [`WM_ROWS];

	// read sees the old word on a same-row write
	always_ff @(posedge clk) begin
		if (port.wr_en)
			mem[port.wr_row] <= port.wr_data;
		if (port.rd_en)
			port.rd_data <= mem[port.rd_row]; // held until the next read
	end

	a_wr_row_known: assert property (@(posedge clk)
		port.wr_en |-> !$isunknown(port.wr_row))
		else $error("bank write with unknown row");

	a_rd_row_known: assert property (@(posedge clk)
		port.rd_en |-> !$isunknown(port.rd_row))
		else $error("bank read with unknown row");

endmodule

`default_nettype wire

//--- weight_read_select.sv
`timescale 1ns/1ns
`default_nettype none
`include "weight_mem_consts.svh"

module weight_read_select (
	bank_port_if.bank banks [`WM_BANKS],
	input weight_mem_pkg::rd_kind_e rd_kind,
	input logic [1:0] rd_bank,
	output weight_mem_pkg::bank_word_t rd_data_cnn,
	output weight_mem_pkg::fc_word_t rd_data_fc
);
	import weight_mem_pkg::*;

	localparam int WORD_W = $bits(bank_word_t);

	bank_word_t bank_q [`WM_BANKS];

	for (genvar g = 0; g < `WM_BANKS; g++) begin : g_collect
		assign bank_q[g] = banks[g].rd_data;
	end

	// outputs stay zero unless a read landed this cycle
	always_comb begin
		rd_data_cnn = '0;
		rd_data_fc = '0;
		case (rd_kind)
			RD_CNN: rd_data_cnn = bank_q[rd_bank];
			RD_FC: begin
				for (int b = 0; b < `WM_BANKS; b++)
					rd_data_fc[b*WORD_W +: WORD_W] = bank_q[b]; // bank 0 lowest
			end
			default: ;
		endcase
	end

	// cnn tag needs a known bank index
	always_comb begin
		a_cnn_bank_known: assert ((rd_kind !== RD_CNN) || !$isunknown(rd_bank))
			else $error("cnn read tagged with unknown bank");
	end

endmodule

`default_nettype wire

//--- weight_memory.sv
`timescale 1ns/1ns
`default_nettype none
`include "weight_mem_consts.svh"

module weight_memory (
	input logic clk,
	input logic reset,
	input logic wr_en_cnn,
	input logic wr_en_fc,
	input logic rd_en,
	input weight_mem_pkg::wm_mode_e mode,
	input weight_mem_pkg::ext_addr_t wr_addr_cnn,
	input weight_mem_pkg::ext_addr_t wr_addr_fc,
	input weight_mem_pkg::ext_addr_t rd_addr_cnn,
	input weight_mem_pkg::ext_addr_t rd_addr_fc,
	input weight_mem_pkg::bank_word_t wr_data_cnn,
	input weight_mem_pkg::bank_word_t wr_data_fc,
	input weight_mem_pkg::row_addr_t fc_base,
	output weight_mem_pkg::bank_word_t rd_data_cnn,
	output weight_mem_pkg::fc_word_t rd_data_fc
);
	import weight_mem_pkg::*;

	rd_kind_e rd_kind; // registered in the decoder
	logic [1:0] rd_bank;

	bank_port_if bank_if [`WM_BANKS] ();

	weight_addr_decode i_weight_addr_decode (
		.clk(clk),
		.reset(reset),
		.wr_en_cnn(wr_en_cnn),
		.wr_en_fc(wr_en_fc),
		.rd_en(rd_en),
		.mode(mode),
		.wr_addr_cnn(wr_addr_cnn),
		.wr_addr_fc(wr_addr_fc),
		.rd_addr_cnn(rd_addr_cnn),
		.rd_addr_fc(rd_addr_fc),
		.wr_data_cnn(wr_data_cnn),
		.wr_data_fc(wr_data_fc),
		.fc_base(fc_base),
		.banks(bank_if),
		.rd_kind(rd_kind),
		.rd_bank(rd_bank)
	);

	for (genvar g = 0; g < `WM_BANKS; g++) begin : g_bank
		weight_bank i_weight_bank (
			.clk(clk),
			.port(bank_if[g])
		);
	end

	weight_read_select i_weight_read_select (
		.banks(bank_if),
		.rd_kind(rd_kind),
		.rd_bank(rd_bank),
		.rd_data_cnn(rd_data_cnn),
		.rd_data_fc(rd_data_fc)
	);

endmodule

`default_nettype wire

//--- weight_memory_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "weight_mem_consts.svh"

module weight_memory_tb;
	import weight_mem_pkg::*;

	localparam int MAX_CYCLES = 1000;

	// one row of the stimulus table, same addresses used for write and read
	typedef struct packed {
		logic wr_cnn;
		logic wr_fc;
		logic rd;
		logic fc_mode;
		ext_addr_t cnn_addr;
		ext_addr_t fc_addr;
		row_addr_t base;
	} step_t;

	logic clk;
	logic reset;
	logic wr_en_cnn;
	logic wr_en_fc;
	logic rd_en;
	wm_mode_e mode;
	ext_addr_t wr_addr_cnn;
	ext_addr_t wr_addr_fc;
	ext_addr_t rd_addr_cnn;
	ext_addr_t rd_addr_fc;
	bank_word_t wr_data_cnn;
	bank_word_t wr_data_fc;
	row_addr_t fc_base;
	bank_word_t rd_data_cnn;
	fc_word_t rd_data_fc;

	step_t steps [$];
	bank_word_t model [`WM_BANKS][`WM_ROWS]; // indexed by bank, row
	logic [31:0] lcg_state;
	bank_word_t cur_cnn_data;
	bank_word_t cur_fc_data;
	bank_word_t exp_cnn;
	fc_word_t exp_fc;
	int errors;
	int checks;

	weight_memory i_weight_memory (
		.clk(clk),
		.reset(reset),
		.wr_en_cnn(wr_en_cnn),
		.wr_en_fc(wr_en_fc),
		.rd_en(rd_en),
		.mode(mode),
		.wr_addr_cnn(wr_addr_cnn),
		.wr_addr_fc(wr_addr_fc),
		.rd_addr_cnn(rd_addr_cnn),
		.rd_addr_fc(rd_addr_fc),
		.wr_data_cnn(wr_data_cnn),
		.wr_data_fc(wr_data_fc),
		.fc_base(fc_base),
		.rd_data_cnn(rd_data_cnn),
		.rd_data_fc(rd_data_fc)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input fc_word_t got, input fc_word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic add_step(input logic wc, input logic wf, input logic rd, input logic fcm,
			input ext_addr_t ca, input ext_addr_t fa, input row_addr_t base);
		step_t s;
		s.wr_cnn = wc;
		s.wr_fc = wf;
		s.rd = rd;
		s.fc_mode = fcm;
		s.cnn_addr = ca;
		s.fc_addr = fa;
		s.base = base;
		steps.push_back(s);
	endtask

	task automatic build_table();
		// cnn write then read, bits 11:10 of the address ignored
		add_step(1, 0, 0, 0, 12'h1a5, 12'h000, 8'h00);
		add_step(0, 0, 1, 0, 12'h1a5, 12'h000, 8'h00);
		add_step(0, 0, 0, 0, 12'h000, 12'h000, 8'h00);
		add_step(1, 0, 0, 0, 12'h312, 12'h000, 8'h00);
		add_step(0, 0, 1, 0, 12'hf12, 12'h000, 8'h00);
		add_step(1, 0, 0, 0, 12'hc07, 12'h000, 8'h00);
		add_step(0, 0, 1, 0, 12'h007, 12'h000, 8'h00);
		// offset 0x1d plus base 0xf0 wraps to row 0x0d
		add_step(0, 1, 0, 1, 12'h000, 12'h071, 8'hf0);
		add_step(0, 1, 0, 1, 12'h000, 12'h075, 8'hf0);
		add_step(0, 1, 0, 1, 12'h000, 12'h079, 8'hf0);
		add_step(0, 1, 0, 1, 12'h000, 12'h07d, 8'hf0);
		// top offset bits drop out, row 0x2e
		add_step(0, 1, 0, 1, 12'h000, 12'hc32, 8'h20);
		add_step(0, 1, 0, 1, 12'h000, 12'hc36, 8'h20);
		add_step(0, 1, 0, 1, 12'h000, 12'hc3a, 8'h20);
		add_step(0, 1, 0, 1, 12'h000, 12'hc3e, 8'h20);
		add_step(0, 0, 1, 1, 12'h000, 12'h071, 8'hf0);
		add_step(0, 0, 1, 1, 12'h000, 12'hc3e, 8'h20);
		add_step(0, 0, 1, 0, 12'h20d, 12'h000, 8'h00); // bank 2 row 0x0d seen from cnn
		// alternating reads every cycle
		add_step(0, 0, 1, 0, 12'h1a5, 12'h000, 8'h00);
		add_step(0, 0, 1, 1, 12'h000, 12'h075, 8'hf0);
		add_step(0, 0, 1, 0, 12'h312, 12'h000, 8'h00);
		add_step(0, 0, 1, 1, 12'h000, 12'hc32, 8'h20);
		add_step(0, 0, 1, 0, 12'h007, 12'h000, 8'h00);
		add_step(0, 0, 1, 1, 12'h000, 12'h07d, 8'hf0);
		add_step(0, 0, 0, 0, 12'h000, 12'h000, 8'h00);
		// both writes on bank 2 row 0x40
		add_step(1, 1, 0, 0, 12'h240, 12'h108, 8'h00);
		add_step(0, 0, 1, 0, 12'h240, 12'h000, 8'h00);
		// both writes, bank 0 and bank 1 at row 0x50
		add_step(1, 1, 0, 0, 12'h050, 12'h144, 8'h00);
		add_step(0, 0, 1, 0, 12'h050, 12'h000, 8'h00);
		add_step(0, 0, 1, 0, 12'h150, 12'h000, 8'h00);
		// read during write of the same row
		add_step(1, 0, 1, 0, 12'h1a5, 12'h000, 8'h00);
		add_step(0, 0, 1, 0, 12'h1a5, 12'h000, 8'h00);
		add_step(0, 1, 1, 1, 12'h000, 12'h075, 8'hf0);
		add_step(0, 0, 1, 1, 12'h000, 12'h071, 8'hf0);
		add_step(0, 0, 0, 0, 12'h000, 12'h000, 8'h00);
	endtask

	task automatic apply_step(input step_t s);
		cur_cnn_data = lcg_next();
		cur_fc_data = lcg_next();
		wr_en_cnn <= s.wr_cnn;
		wr_en_fc <= s.wr_fc;
		rd_en <= s.rd;
		mode <= s.fc_mode ? MODE_FC : MODE_CNN;
		wr_addr_cnn <= s.cnn_addr;
		rd_addr_cnn <= s.cnn_addr;
		wr_addr_fc <= s.fc_addr;
		rd_addr_fc <= s.fc_addr;
		fc_base <= s.base;
		wr_data_cnn <= cur_cnn_data;
		wr_data_fc <= cur_fc_data;
	endtask

	// read result first, so a same-cycle write is not yet visible
	task automatic predict(input step_t s);
		logic [1:0] cb;
		logic [1:0] fb;
		logic [7:0] cr;
		logic [7:0] fr;
		cb = s.cnn_addr[9:8];
		cr = s.cnn_addr[7:0];
		fb = s.fc_addr[3:2];
		fr = {s.fc_addr[9:4], s.fc_addr[1:0]} + s.base;
		exp_cnn = '0;
		exp_fc = '0;
		if (s.rd && !s.fc_mode)
			exp_cnn = model[cb][cr];
		if (s.rd && s.fc_mode)
			exp_fc = {model[3][fr], model[2][fr], model[1][fr], model[0][fr]};
		if (s.wr_cnn && !(s.wr_fc && (fb == cb)))
			model[cb][cr] = cur_cnn_data; // dropped when fc takes the bank
		if (s.wr_fc)
			model[fb][fr] = cur_fc_data;
	endtask

	initial begin
		step_t s;
		reset = 1'b0;
		wr_en_cnn = 1'b0;
		wr_en_fc = 1'b0;
		rd_en = 1'b0;
		mode = MODE_CNN;
		wr_addr_cnn = '0;
		wr_addr_fc = '0;
		rd_addr_cnn = '0;
		rd_addr_fc = '0;
		wr_data_cnn = '0;
		wr_data_fc = '0;
		fc_base = '0;
		lcg_state = 32'h286a_a395;
		errors = 0;
		checks = 0;
		build_table();

		for (int c = 0; c < 5; c++) begin
			@(posedge clk);
			if (c == 4)
				reset <= 1'b1;
			@(negedge clk);
			check_value(fc_word_t'(rd_data_cnn), '0, "rd_data_cnn around reset");
			check_value(rd_data_fc, '0, "rd_data_fc around reset");
		end

		exp_cnn = '0;
		exp_fc = '0;
		for (int i = 0; i <= steps.size(); i++) begin
			@(posedge clk);
			if (i < steps.size())
				s = steps[i];
			else
				s = '0;
			apply_step(s);
			@(negedge clk);
			// data of the previous row's read
			check_value(fc_word_t'(rd_data_cnn), fc_word_t'(exp_cnn),
				$sformatf("rd_data_cnn after row %0d", i - 1));
			check_value(rd_data_fc, exp_fc, $sformatf("rd_data_fc after row %0d", i - 1));
			predict(s);
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// watchdog
	initial begin
		for (int c = 0; c < MAX_CYCLES; c++)
			@(posedge clk);
		$display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
weight_mem_pkg.sv
bank_port_if.sv
weight_addr_decode.sv
weight_bank.sv
weight_read_select.sv
weight_memory.sv
weight_memory_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --timing --assert
TOP ?= weight_memory_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
